//--- tb.f
src/ev_packet_pkg.sv
src/ev_ctrl_pkg.sv
src/ev_session_fsm.sv
src/ev_round_reader.sv
src/a2b_packet_writer.sv
src/ev_sender_top.sv
dv/ev_sender_tb.sv

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 --top-module ev_sender_tb \
    -f tb.f -o ev_sender_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ev_sender_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$SIM_LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- dv/ev_sender_tb.sv
`timescale 1ns/1ps

module ev_sender_tb;

    localparam int NUM_ROUNDS   = 4;
    localparam int ROUND_WORDS  = 8;
    localparam int DEPTH        = NUM_ROUNDS * ROUND_WORDS;
    localparam int PKT_WORDS    = 2 * ROUND_WORDS + 1;  // Header plus two halves per BRAM word
    localparam int NUM_SESSIONS = 3;
    localparam int STALL_CYCLES = 40;
    localparam int CLK_PERIOD   = 4;
    localparam int TIMEOUT_NS   =
        NUM_SESSIONS * NUM_ROUNDS * (2 * ROUND_WORDS + STALL_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        start_a_er;
    logic        start_tx;
    logic        a2b_empty;
    logic [63:0] ev_dout;
    logic        wait_tx;
    logic        finish_a_er;
    logic [13:0] ev_addr;
    logic        a2b_wr_en;
    logic [31:0] a2b_wr_din;

    logic [63:0]   bram [0:DEPTH-1];
    logic [31:0]   exp_q[$];   // Reference word stream of the current session
    logic [31:0]   fifo_q[$];  // Words written by the DUT, drained per round
    logic [31:0]   rng;
    logic [13:0]   rd_addr;
    logic [2:0]    empty_hist;
    int            stall_cnt;
    int            finish_count;

    ev_sender_top #(
        .NUM_ROUNDS  (NUM_ROUNDS),
        .ROUND_WORDS (ROUND_WORDS)
    ) i_ev_sender_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_a_er  (start_a_er),
        .start_tx    (start_tx),
        .a2b_empty   (a2b_empty),
        .ev_dout     (ev_dout),
        .wait_tx     (wait_tx),
        .finish_a_er (finish_a_er),
        .ev_addr     (ev_addr),
        .a2b_wr_en   (a2b_wr_en),
        .a2b_wr_din  (a2b_wr_din)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Header, then upper and lower half of each word of the round, per round
    task automatic build_expected();
        int          r;
        int          i;
        logic [63:0] w;
        for (r = 0; r < NUM_ROUNDS; r++) begin
            exp_q.push_back({4'h1, 12'(PKT_WORDS), 8'h00, 8'(r)});
            for (i = 0; i < ROUND_WORDS; i++) begin
                w = bram[r * ROUND_WORDS + i];
                exp_q.push_back(w[63:32]);
                exp_q.push_back(w[31:0]);
            end
        end
    endtask

    task automatic drain_packet();
        int i;
        for (i = 0; i < PKT_WORDS; i++) begin
            check_value($sformatf("a2b_wr_din word %0d", i), 64'(fifo_q[i]),
                        64'(exp_q.pop_front()));
        end
        fifo_q.delete();
        rng       = xorshift32(rng);
        stall_cnt = int'(rng[3:0]);  // Hold empty low a while before the next round
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // BRAM with one cycle of read latency, and the FIFO empty flag
    initial begin
        ev_dout   = 64'd0;
        a2b_empty = 1'b1;
        rd_addr   = '0;
        forever begin
            @(posedge clk);
            #1;
            ev_dout = (rd_addr < DEPTH) ? bram[rd_addr] : 'x;  // Past the model reads unknown
            rd_addr = ev_addr;
            if (stall_cnt > 0) stall_cnt--;
            a2b_empty = (fifo_q.size() == 0) && (stall_cnt == 0);
        end
    end

    // Output monitor, samples on the falling edge
    initial begin
        empty_hist   = 3'b000;
        finish_count = 0;
        forever begin
            @(negedge clk);
            empty_hist = {empty_hist[1:0], a2b_empty};
            if (finish_a_er) begin
                finish_count++;
                check_value("words left at finish_a_er", 64'(exp_q.size()), 64'd0);
            end
            if (a2b_wr_en) begin
                if (wait_tx) report_failure("FIFO write while waiting for start_tx");
                if (exp_q.size() == 0) report_failure("FIFO write with no word expected");
                if (fifo_q.size() == 0) begin
                    // Count started two cycles before the header write
                    check_value("a2b_empty at packet start", 64'(empty_hist[2]), 64'd1);
                end
                fifo_q.push_back(a2b_wr_din);
                if (fifo_q.size() == PKT_WORDS) drain_packet();
            end else if (rst_n) begin
                check_value("a2b_wr_din", 64'(a2b_wr_din), 64'd0);  // Bus cleared when idle
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure("run timed out before all sessions finished");
    end

    initial begin
        int s;
        int i;
        int delay;
        rst_n      = 1'b0;
        start_a_er = 1'b0;
        start_tx   = 1'b0;
        stall_cnt  = 0;
        rng        = 32'h8100_4874;
        for (i = 0; i < DEPTH; i++) begin
            rng = xorshift32(rng);
            bram[i][63:32] = rng;
            rng = xorshift32(rng);
            bram[i][31:0] = rng;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (6) begin  // Quiet before any start
            @(negedge clk);
            check_value("wait_tx", 64'(wait_tx), 64'd0);
            check_value("finish_a_er", 64'(finish_a_er), 64'd0);
            check_value("a2b_wr_en", 64'(a2b_wr_en), 64'd0);
        end

        for (s = 0; s < NUM_SESSIONS; s++) begin
            build_expected();
            rng       = xorshift32(rng);
            delay     = int'(rng[2:0]) + 1;
            rng       = xorshift32(rng);
            stall_cnt = int'(rng[3:0]);
            @(posedge clk);
            #1 start_a_er = 1'b1;
            @(posedge clk);
            #1 start_a_er = 1'b0;
            repeat (delay) begin
                @(negedge clk);
                check_value("wait_tx", 64'(wait_tx), 64'd1);
                @(posedge clk);
                #1;
            end
            start_tx = 1'b1;
            do @(negedge clk); while (!finish_a_er);
            @(posedge clk);
            #1 start_tx = 1'b0;
            repeat (4) @(negedge clk);
            check_value("finish_a_er pulse count", 64'(finish_count), 64'(s + 1));
            check_value("wait_tx", 64'(wait_tx), 64'd0);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src/ev_sender_top.sv
`timescale 1ns/1ps

module ev_sender_top
    import ev_packet_pkg::*;
#(
    parameter int NUM_ROUNDS  = 32,
    parameter int ROUND_WORDS = 512
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_a_er,
    input  logic      start_tx,
    input  logic      a2b_empty,
    input  ev_word_t  ev_dout,
    output logic      wait_tx,
    output logic      finish_a_er,
    output ev_addr_t  ev_addr,
    output logic      a2b_wr_en,
    output a2b_word_t a2b_wr_din
);

    logic      send_en;
    logic      send_done;
    logic      hdr_req;
    logic      data_valid;
    a2b_word_t data_word;
    round_t    round;

    ev_session_fsm i_ev_session_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_a_er  (start_a_er),
        .start_tx    (start_tx),
        .send_done   (send_done),
        .wait_tx     (wait_tx),
        .send_en     (send_en),
        .finish_a_er (finish_a_er)
    );

    ev_round_reader #(
        .NUM_ROUNDS  (NUM_ROUNDS),
        .ROUND_WORDS (ROUND_WORDS)
    ) i_ev_round_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .send_en    (send_en),
        .a2b_empty  (a2b_empty),
        .ev_dout    (ev_dout),
        .ev_addr    (ev_addr),
        .send_done  (send_done),
        .hdr_req    (hdr_req),
        .data_valid (data_valid),
        .data_word  (data_word),
        .round      (round)
    );

    a2b_packet_writer #(
        .ROUND_WORDS (ROUND_WORDS)
    ) i_a2b_packet_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_req    (hdr_req),
        .round      (round),
        .data_valid (data_valid),
        .data_word  (data_word),
        .a2b_wr_en  (a2b_wr_en),
        .a2b_wr_din (a2b_wr_din)
    );

endmodule

//--- src/a2b_packet_writer.sv
`timescale 1ns/1ps

module a2b_packet_writer
    import ev_packet_pkg::*;
#(
    parameter int ROUND_WORDS = 512
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hdr_req,
    input  round_t    round,
    input  logic      data_valid,
    input  a2b_word_t data_word,
    output logic      a2b_wr_en,
    output a2b_word_t a2b_wr_din
);

    // Header plus two FIFO words per BRAM word
    localparam pkt_len_t PKT_LEN = pkt_len_t'(2 * ROUND_WORDS + 1);

    a2b_word_t header;

    assign header = {EV_PKT_TYPE, PKT_LEN, {HDR_PAD_W{1'b0}}, round};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a2b_wr_en  <= 1'b0;
            a2b_wr_din <= '0;
        end else if (hdr_req) begin
            a2b_wr_en  <= 1'b1;
            a2b_wr_din <= header;
        end else if (data_valid) begin
            a2b_wr_en  <= 1'b1;
            a2b_wr_din <= data_word;
        end else begin
            // Idle, keep the bus quiet
            a2b_wr_en  <= 1'b0;
            a2b_wr_din <= '0;
        end
    end

    // Header slot and data stream come from different pipeline depths in the reader
    a_hdr_data_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hdr_req && data_valid)
    ) else $error("header request collides with a data word");

endmodule

//--- src/ev_round_reader.sv
`timescale 1ns/1ps

module ev_round_reader
    import ev_packet_pkg::*;
    import ev_ctrl_pkg::*;
#(
    parameter int NUM_ROUNDS  = 32,
    parameter int ROUND_WORDS = 512
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      send_en,
    input  logic      a2b_empty,
    input  ev_word_t  ev_dout,
    output ev_addr_t  ev_addr,
    output logic      send_done,
    output logic      hdr_req,
    output logic      data_valid,
    output a2b_word_t data_word,
    output round_t    round
);

    localparam int HCNT_W   = $clog2(2 * ROUND_WORDS);  // Half-word counter width
    localparam int LAST_CNT = 2 * ROUND_WORDS - 1;

    round_state_t      state;
    logic [HCNT_W-1:0] cnt;
    logic              count_start;
    logic              count_last;
    logic [31:0]       addr_full;
    logic [1:0]        cnt_en_d;   // Count enable, BRAM and output stages
    logic [1:0]        lsb_d;      // Half select, same alignment
    ev_word_t          ev_dout_q;

    assign count_start = (state == R_WAIT_EMPTY) && a2b_empty;
    assign count_last  = (state == R_COUNT) && (cnt == HCNT_W'(LAST_CNT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE:       state <= send_en ? R_START : R_IDLE;
                R_START:      state <= R_WAIT_EMPTY;
                R_WAIT_EMPTY: state <= a2b_empty ? R_COUNT : R_WAIT_EMPTY;
                R_COUNT:      state <= count_last ? R_COUNT_END : R_COUNT;
                R_COUNT_END:  state <= (round == round_t'(NUM_ROUNDS - 1)) ? R_END : R_WAIT_EMPTY;
                R_END:        state <= R_IDLE;
                default:      state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= '0;
            hdr_req <= 1'b0;
            round   <= '0;
        end else begin
            hdr_req <= count_start;  // High in the first counting cycle
            if (count_start) begin
                cnt <= '0;
            end else if (state == R_COUNT) begin
                cnt <= cnt + 1'b1;
            end
            if (state == R_COUNT_END) begin
                round <= round + 1'b1;
            end else if (state == R_END) begin
                round <= '0;  // Next session starts again at round 0
            end
        end
    end

    // Two FIFO words per BRAM word
    assign addr_full = 32'(round) * ROUND_WORDS + 32'(cnt[HCNT_W-1:1]);
    assign ev_addr   = ev_addr_t'(addr_full);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_en_d <= 2'b00;
        end else begin
            cnt_en_d <= {cnt_en_d[0], state == R_COUNT};
        end
    end

    always_ff @(posedge clk) begin
        lsb_d     <= {lsb_d[0], cnt[0]};
        ev_dout_q <= ev_dout;  // Extra register after the BRAM
    end

    assign data_valid = cnt_en_d[1];
    assign data_word  = lsb_d[1] ? ev_dout_q[31:0] : ev_dout_q[63:32];  // Upper half on even
    assign send_done  = (state == R_END);

    // Round addressing must stay inside the BRAM and the session's region
    a_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == R_COUNT) |->
            (addr_full < NUM_ROUNDS * ROUND_WORDS) && (addr_full < 2 ** $bits(ev_addr_t))
    ) else $error("ev_addr out of range: %0d", addr_full);

endmodule

//--- src/ev_session_fsm.sv
`timescale 1ns/1ps

module ev_session_fsm
    import ev_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start_a_er,
    input  logic start_tx,
    input  logic send_done,
    output logic wait_tx,
    output logic send_en,
    output logic finish_a_er
);

    session_state_t state;
    session_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_a_er) begin
                    state_nxt = WAIT_TX;
                end
            end
            WAIT_TX: begin
                if (start_tx) begin  // Both boards ready
                    state_nxt = START;
                end
            end
            START: begin
                state_nxt = SEND;
            end
            SEND: begin
                if (send_done) begin
                    state_nxt = SEND_END;
                end
            end
            SEND_END: begin
                state_nxt = DONE;
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Outputs decoded straight from the state register
    assign wait_tx     = (state == WAIT_TX);
    assign send_en     = (state == SEND);     // Held for the whole send phase
    assign finish_a_er = (state == DONE);

    // Reader may only report done while the send phase is active
    a_done_in_send: assert property (
        @(posedge clk) disable iff (!rst_n)
        send_done |-> send_en
    ) else $error("send_done outside the send phase");

endmodule

//--- src/ev_ctrl_pkg.sv
package ev_ctrl_pkg;

    // Session level sequencing on Alice's side
    typedef enum logic [2:0] {
        IDLE,
        WAIT_TX,   // Waiting for Bob to be ready
        START,
        SEND,      // Random-bit rounds in progress
        SEND_END,
        DONE       // Finish pulse
    } session_state_t;

    // Per-round sequencing of the random-bit sender
    typedef enum logic [2:0] {
        R_IDLE,
        R_START,
        R_WAIT_EMPTY,  // Back-pressure point between rounds
        R_COUNT,       // One cycle per FIFO data word
        R_COUNT_END,
        R_END
    } round_state_t;

endpackage

//--- src/ev_packet_pkg.sv
package ev_packet_pkg;

    // One word of the A2B FIFO
    typedef logic [31:0] a2b_word_t;

    // One word of the random-bit BRAM
    typedef logic [63:0] ev_word_t;

    // Random-bit BRAM address, 16384 words deep
    typedef logic [13:0] ev_addr_t;

    // Round number carried in the packet header
    typedef logic [7:0] round_t;

    // Header field widths, MSB first: type, length, pad, round
    localparam int HDR_TYPE_W = 4;
    localparam int HDR_LEN_W  = 12;
    localparam int HDR_PAD_W  = 8;

    // Packet length field, counts the header word too
    typedef logic [HDR_LEN_W-1:0] pkt_len_t;

    // Packet type code for error-verification random bits
    localparam logic [HDR_TYPE_W-1:0] EV_PKT_TYPE = 4'h1;

endpackage
